/* axi_cdc_pkg.sv */
// Shared widths, types and gray-code helper for the AXI4-Lite clock domain crossing.
// AXI4-Lite only: no IDs, bursts or user bits.
// FIFO depth is 2**LOG_DEPTH and must be at least 2 entries.
package axi_cdc_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned LOG_DEPTH  = 2;
  localparam int unsigned DEPTH      = 2 ** LOG_DEPTH;

  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [DATA_WIDTH/8-1:0] strb_t;
  typedef logic [1:0]              resp_t;
  typedef logic [2:0]              prot_t;
  typedef logic [LOG_DEPTH:0]      ptr_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // A full FIFO shows gray pointers that differ only in their two top bits
  localparam ptr_t PTR_FULL_MASK = ptr_t'(3) << (LOG_DEPTH - 1);

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_rsp_t;

  function automatic ptr_t bin2gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage

/* cdc_fifo_src.sv */
// Write half of a gray-pointer asynchronous FIFO.
// arst_n_i must already be synchronized to src_clk_i.
// async_data_o and async_wptr_o are read in another clock domain, so their
// paths to the read half need max-delay constraints in the implementation flow.
module cdc_fifo_src #(
  parameter type chan_t = logic
) (
  input  logic                                src_clk_i,
  input  logic                                arst_n_i,
  input  chan_t                               data_i,
  input  logic                                valid_i,
  output logic                                ready_o,
  output chan_t [axi_cdc_pkg::DEPTH-1:0]      async_data_o,
  output axi_cdc_pkg::ptr_t                   async_wptr_o,
  input  axi_cdc_pkg::ptr_t                   async_rptr_i
);

  chan_t [axi_cdc_pkg::DEPTH-1:0] mem_q;
  axi_cdc_pkg::ptr_t wptr_bin_q, wptr_bin_d;
  axi_cdc_pkg::ptr_t wptr_gray_q, wptr_gray_d;
  axi_cdc_pkg::ptr_t rptr_q1, rptr_q2;
  logic push, full, ready_q;

  assign push        = valid_i & ready_q;
  assign wptr_bin_d  = wptr_bin_q + axi_cdc_pkg::ptr_t'(push);
  assign wptr_gray_d = axi_cdc_pkg::bin2gray(wptr_bin_d);
  // Full as seen from the current pointers
  assign full        = wptr_gray_q == (rptr_q2 ^ axi_cdc_pkg::PTR_FULL_MASK);

  always_ff @(posedge src_clk_i) begin
    if (push) begin
      mem_q[wptr_bin_q[axi_cdc_pkg::LOG_DEPTH-1:0]] <= data_i;
    end
  end

  always_ff @(posedge src_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
      rptr_q1     <= '0;
      rptr_q2     <= '0;
      ready_q     <= 1'b0;
    end else begin
      wptr_bin_q  <= wptr_bin_d;
      wptr_gray_q <= wptr_gray_d;
      rptr_q1     <= async_rptr_i;
      rptr_q2     <= rptr_q1;
      // Ready is computed from next-cycle pointers so it stays a flop
      ready_q     <= wptr_gray_d != (rptr_q1 ^ axi_cdc_pkg::PTR_FULL_MASK);
    end
  end

  assign ready_o      = ready_q;
  assign async_data_o = mem_q;
  assign async_wptr_o = wptr_gray_q;

  // The pointer seen by the other domain moves one bit at a time
  assert property (@(posedge src_clk_i) disable iff (!arst_n_i)
    $countones(wptr_gray_q ^ $past(wptr_gray_q)) <= 1);

  assert property (@(posedge src_clk_i) disable iff (!arst_n_i) push |-> !full);

endmodule

/* cdc_fifo_dst.sv */
// Read half of a gray-pointer asynchronous FIFO.
// arst_n_i must already be synchronized to dst_clk_i.
// async_data_i is sampled without synchronization; it is only read
// once the synchronized write pointer shows the entry as written.
module cdc_fifo_dst #(
  parameter type chan_t = logic
) (
  input  logic                                dst_clk_i,
  input  logic                                arst_n_i,
  output chan_t                               data_o,
  output logic                                valid_o,
  input  logic                                ready_i,
  input  chan_t [axi_cdc_pkg::DEPTH-1:0]      async_data_i,
  input  axi_cdc_pkg::ptr_t                   async_wptr_i,
  output axi_cdc_pkg::ptr_t                   async_rptr_o
);

  axi_cdc_pkg::ptr_t rptr_bin_q, rptr_bin_d;
  axi_cdc_pkg::ptr_t rptr_gray_q;
  axi_cdc_pkg::ptr_t wptr_q1, wptr_q2;
  logic pop;

  // Entries are waiting while the gray pointers differ
  assign valid_o    = wptr_q2 != rptr_gray_q;
  assign pop        = valid_o & ready_i;
  assign rptr_bin_d = rptr_bin_q + axi_cdc_pkg::ptr_t'(pop);
  assign data_o     = async_data_i[rptr_bin_q[axi_cdc_pkg::LOG_DEPTH-1:0]];

  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_bin_q  <= '0;
      rptr_gray_q <= '0;
      wptr_q1     <= '0;
      wptr_q2     <= '0;
    end else begin
      rptr_bin_q  <= rptr_bin_d;
      rptr_gray_q <= axi_cdc_pkg::bin2gray(rptr_bin_d);
      wptr_q1     <= async_wptr_i;
      wptr_q2     <= wptr_q1;
    end
  end

  assign async_rptr_o = rptr_gray_q;

  // A stalled beat keeps its payload while the write side keeps filling
  assert property (@(posedge dst_clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

/* axi_cdc_src.sv */
// Source-domain side of the AXI4-Lite crossing, all logic on src_clk_i.
// Pushes AW, W and AR into FIFO write halves, pops B and R from read halves.
// arst_n_i is asynchronous; release is synchronized here through two flops.
module axi_cdc_src (
  input  logic                                                  src_clk_i,
  input  logic                                                  arst_n_i,
  input  axi_cdc_pkg::axi_req_t                                 src_req_i,
  output axi_cdc_pkg::axi_rsp_t                                 src_resp_o,
  output axi_cdc_pkg::aw_chan_t [axi_cdc_pkg::DEPTH-1:0]        async_aw_data_o,
  output axi_cdc_pkg::ptr_t                                     async_aw_wptr_o,
  input  axi_cdc_pkg::ptr_t                                     async_aw_rptr_i,
  output axi_cdc_pkg::w_chan_t [axi_cdc_pkg::DEPTH-1:0]         async_w_data_o,
  output axi_cdc_pkg::ptr_t                                     async_w_wptr_o,
  input  axi_cdc_pkg::ptr_t                                     async_w_rptr_i,
  input  axi_cdc_pkg::b_chan_t [axi_cdc_pkg::DEPTH-1:0]         async_b_data_i,
  input  axi_cdc_pkg::ptr_t                                     async_b_wptr_i,
  output axi_cdc_pkg::ptr_t                                     async_b_rptr_o,
  output axi_cdc_pkg::ar_chan_t [axi_cdc_pkg::DEPTH-1:0]        async_ar_data_o,
  output axi_cdc_pkg::ptr_t                                     async_ar_wptr_o,
  input  axi_cdc_pkg::ptr_t                                     async_ar_rptr_i,
  input  axi_cdc_pkg::r_chan_t [axi_cdc_pkg::DEPTH-1:0]         async_r_data_i,
  input  axi_cdc_pkg::ptr_t                                     async_r_wptr_i,
  output axi_cdc_pkg::ptr_t                                     async_r_rptr_o
);

  logic [1:0] rst_sync_q;
  logic       rst_n;

  always_ff @(posedge src_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_n = rst_sync_q[1];

  // Request channels leave this domain
  cdc_fifo_src #(.chan_t(axi_cdc_pkg::aw_chan_t)) i_aw_src (
    .src_clk_i    (src_clk_i),
    .arst_n_i     (rst_n),
    .data_i       (src_req_i.aw),
    .valid_i      (src_req_i.aw_valid),
    .ready_o      (src_resp_o.aw_ready),
    .async_data_o (async_aw_data_o),
    .async_wptr_o (async_aw_wptr_o),
    .async_rptr_i (async_aw_rptr_i)
  );

  cdc_fifo_src #(.chan_t(axi_cdc_pkg::w_chan_t)) i_w_src (
    .src_clk_i    (src_clk_i),
    .arst_n_i     (rst_n),
    .data_i       (src_req_i.w),
    .valid_i      (src_req_i.w_valid),
    .ready_o      (src_resp_o.w_ready),
    .async_data_o (async_w_data_o),
    .async_wptr_o (async_w_wptr_o),
    .async_rptr_i (async_w_rptr_i)
  );

  cdc_fifo_src #(.chan_t(axi_cdc_pkg::ar_chan_t)) i_ar_src (
    .src_clk_i    (src_clk_i),
    .arst_n_i     (rst_n),
    .data_i       (src_req_i.ar),
    .valid_i      (src_req_i.ar_valid),
    .ready_o      (src_resp_o.ar_ready),
    .async_data_o (async_ar_data_o),
    .async_wptr_o (async_ar_wptr_o),
    .async_rptr_i (async_ar_rptr_i)
  );

  // Responses arrive from the destination domain
  cdc_fifo_dst #(.chan_t(axi_cdc_pkg::b_chan_t)) i_b_dst (
    .dst_clk_i    (src_clk_i),
    .arst_n_i     (rst_n),
    .data_o       (src_resp_o.b),
    .valid_o      (src_resp_o.b_valid),
    .ready_i      (src_req_i.b_ready),
    .async_data_i (async_b_data_i),
    .async_wptr_i (async_b_wptr_i),
    .async_rptr_o (async_b_rptr_o)
  );

  cdc_fifo_dst #(.chan_t(axi_cdc_pkg::r_chan_t)) i_r_dst (
    .dst_clk_i    (src_clk_i),
    .arst_n_i     (rst_n),
    .data_o       (src_resp_o.r),
    .valid_o      (src_resp_o.r_valid),
    .ready_i      (src_req_i.r_ready),
    .async_data_i (async_r_data_i),
    .async_wptr_i (async_r_wptr_i),
    .async_rptr_o (async_r_rptr_o)
  );

endmodule

/* axi_cdc_dst.sv */
// Destination-domain side of the AXI4-Lite crossing, all logic on dst_clk_i.
// Pops AW, W and AR from FIFO read halves, pushes B and R into write halves.
// AW and W are not paired here; the subordinate sees them as independent channels.
module axi_cdc_dst (
  input  logic                                                  dst_clk_i,
  input  logic                                                  arst_n_i,
  output axi_cdc_pkg::axi_req_t                                 dst_req_o,
  input  axi_cdc_pkg::axi_rsp_t                                 dst_resp_i,
  input  axi_cdc_pkg::aw_chan_t [axi_cdc_pkg::DEPTH-1:0]        async_aw_data_i,
  input  axi_cdc_pkg::ptr_t                                     async_aw_wptr_i,
  output axi_cdc_pkg::ptr_t                                     async_aw_rptr_o,
  input  axi_cdc_pkg::w_chan_t [axi_cdc_pkg::DEPTH-1:0]         async_w_data_i,
  input  axi_cdc_pkg::ptr_t                                     async_w_wptr_i,
  output axi_cdc_pkg::ptr_t                                     async_w_rptr_o,
  output axi_cdc_pkg::b_chan_t [axi_cdc_pkg::DEPTH-1:0]         async_b_data_o,
  output axi_cdc_pkg::ptr_t                                     async_b_wptr_o,
  input  axi_cdc_pkg::ptr_t                                     async_b_rptr_i,
  input  axi_cdc_pkg::ar_chan_t [axi_cdc_pkg::DEPTH-1:0]        async_ar_data_i,
  input  axi_cdc_pkg::ptr_t                                     async_ar_wptr_i,
  output axi_cdc_pkg::ptr_t                                     async_ar_rptr_o,
  output axi_cdc_pkg::r_chan_t [axi_cdc_pkg::DEPTH-1:0]         async_r_data_o,
  output axi_cdc_pkg::ptr_t                                     async_r_wptr_o,
  input  axi_cdc_pkg::ptr_t                                     async_r_rptr_i
);

  logic [1:0] rst_sync_q;
  logic       rst_n;

  // Local release of the shared reset
  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_n = rst_sync_q[1];

  cdc_fifo_dst #(.chan_t(axi_cdc_pkg::aw_chan_t)) i_aw_dst (
    .dst_clk_i    (dst_clk_i),
    .arst_n_i     (rst_n),
    .data_o       (dst_req_o.aw),
    .valid_o      (dst_req_o.aw_valid),
    .ready_i      (dst_resp_i.aw_ready),
    .async_data_i (async_aw_data_i),
    .async_wptr_i (async_aw_wptr_i),
    .async_rptr_o (async_aw_rptr_o)
  );

  cdc_fifo_dst #(.chan_t(axi_cdc_pkg::w_chan_t)) i_w_dst (
    .dst_clk_i    (dst_clk_i),
    .arst_n_i     (rst_n),
    .data_o       (dst_req_o.w),
    .valid_o      (dst_req_o.w_valid),
    .ready_i      (dst_resp_i.w_ready),
    .async_data_i (async_w_data_i),
    .async_wptr_i (async_w_wptr_i),
    .async_rptr_o (async_w_rptr_o)
  );

  cdc_fifo_dst #(.chan_t(axi_cdc_pkg::ar_chan_t)) i_ar_dst (
    .dst_clk_i    (dst_clk_i),
    .arst_n_i     (rst_n),
    .data_o       (dst_req_o.ar),
    .valid_o      (dst_req_o.ar_valid),
    .ready_i      (dst_resp_i.ar_ready),
    .async_data_i (async_ar_data_i),
    .async_wptr_i (async_ar_wptr_i),
    .async_rptr_o (async_ar_rptr_o)
  );

  // Responses head back to the source domain
  cdc_fifo_src #(.chan_t(axi_cdc_pkg::b_chan_t)) i_b_src (
    .src_clk_i    (dst_clk_i),
    .arst_n_i     (rst_n),
    .data_i       (dst_resp_i.b),
    .valid_i      (dst_resp_i.b_valid),
    .ready_o      (dst_req_o.b_ready),
    .async_data_o (async_b_data_o),
    .async_wptr_o (async_b_wptr_o),
    .async_rptr_i (async_b_rptr_i)
  );

  cdc_fifo_src #(.chan_t(axi_cdc_pkg::r_chan_t)) i_r_src (
    .src_clk_i    (dst_clk_i),
    .arst_n_i     (rst_n),
    .data_i       (dst_resp_i.r),
    .valid_i      (dst_resp_i.r_valid),
    .ready_o      (dst_req_o.r_ready),
    .async_data_o (async_r_data_o),
    .async_wptr_o (async_r_wptr_o),
    .async_rptr_i (async_r_rptr_i)
  );

endmodule

/* axi_cdc.sv */
// AXI4-Lite clock domain crossing, one gray-pointer FIFO per channel.
// src_clk_i and dst_clk_i may have any frequency and phase relation.
// The data, wptr and rptr buses between the halves cross clock domains and
// need max-delay constraints of about one destination clock period.
// One asynchronous reset serves both domains.
module axi_cdc (
  input  logic                  src_clk_i,
  input  logic                  dst_clk_i,
  input  logic                  arst_n_i,
  input  axi_cdc_pkg::axi_req_t src_req_i,
  output axi_cdc_pkg::axi_rsp_t src_resp_o,
  output axi_cdc_pkg::axi_req_t dst_req_o,
  input  axi_cdc_pkg::axi_rsp_t dst_resp_i
);

  axi_cdc_pkg::aw_chan_t [axi_cdc_pkg::DEPTH-1:0] aw_data;
  axi_cdc_pkg::w_chan_t  [axi_cdc_pkg::DEPTH-1:0] w_data;
  axi_cdc_pkg::b_chan_t  [axi_cdc_pkg::DEPTH-1:0] b_data;
  axi_cdc_pkg::ar_chan_t [axi_cdc_pkg::DEPTH-1:0] ar_data;
  axi_cdc_pkg::r_chan_t  [axi_cdc_pkg::DEPTH-1:0] r_data;
  axi_cdc_pkg::ptr_t aw_wptr, aw_rptr, w_wptr, w_rptr, b_wptr, b_rptr;
  axi_cdc_pkg::ptr_t ar_wptr, ar_rptr, r_wptr, r_rptr;

  axi_cdc_src i_axi_cdc_src (
    .src_clk_i       (src_clk_i),
    .arst_n_i        (arst_n_i),
    .src_req_i       (src_req_i),
    .src_resp_o      (src_resp_o),
    .async_aw_data_o (aw_data),
    .async_aw_wptr_o (aw_wptr),
    .async_aw_rptr_i (aw_rptr),
    .async_w_data_o  (w_data),
    .async_w_wptr_o  (w_wptr),
    .async_w_rptr_i  (w_rptr),
    .async_b_data_i  (b_data),
    .async_b_wptr_i  (b_wptr),
    .async_b_rptr_o  (b_rptr),
    .async_ar_data_o (ar_data),
    .async_ar_wptr_o (ar_wptr),
    .async_ar_rptr_i (ar_rptr),
    .async_r_data_i  (r_data),
    .async_r_wptr_i  (r_wptr),
    .async_r_rptr_o  (r_rptr)
  );

  axi_cdc_dst i_axi_cdc_dst (
    .dst_clk_i       (dst_clk_i),
    .arst_n_i        (arst_n_i),
    .dst_req_o       (dst_req_o),
    .dst_resp_i      (dst_resp_i),
    .async_aw_data_i (aw_data),
    .async_aw_wptr_i (aw_wptr),
    .async_aw_rptr_o (aw_rptr),
    .async_w_data_i  (w_data),
    .async_w_wptr_i  (w_wptr),
    .async_w_rptr_o  (w_rptr),
    .async_b_data_o  (b_data),
    .async_b_wptr_o  (b_wptr),
    .async_b_rptr_i  (b_rptr),
    .async_ar_data_i (ar_data),
    .async_ar_wptr_i (ar_wptr),
    .async_ar_rptr_o (ar_rptr),
    .async_r_data_o  (r_data),
    .async_r_wptr_o  (r_wptr),
    .async_r_rptr_i  (r_rptr)
  );

endmodule

/* tb_clk_gen.sv */
// Free-running testbench clock, starts low.
// OFFSET delays the first rising edge to set the phase.
module tb_clk_gen #(
  parameter int PERIOD = 10,
  parameter int OFFSET = 0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    #(OFFSET);
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

endmodule

/* tb_axi_cdc_checker.sv */
// Watches both sides of the crossing and compares each beat with the
// expected transaction list received from the testbench top.
// Holds up to 64 writes and 64 reads.
module tb_axi_cdc_checker (
  input  logic                  src_clk_i,
  input  logic                  dst_clk_i,
  input  logic                  started_i,
  input  logic                  exp_valid_i,
  input  logic                  exp_write_i,
  input  axi_cdc_pkg::addr_t    exp_addr_i,
  input  axi_cdc_pkg::data_t    exp_data_i,
  input  axi_cdc_pkg::axi_req_t src_req_i,
  input  axi_cdc_pkg::axi_rsp_t src_resp_i,
  input  axi_cdc_pkg::axi_req_t dst_req_i,
  input  axi_cdc_pkg::axi_rsp_t dst_resp_i,
  output int                    error_count_o,
  output int                    b_count_o,
  output int                    r_count_o
);

  axi_cdc_pkg::addr_t wr_addr [64];
  axi_cdc_pkg::data_t wr_data [64];
  axi_cdc_pkg::addr_t rd_addr [64];
  axi_cdc_pkg::data_t rd_data [64];
  int n_wr = 0;
  int n_rd = 0;
  int b_idx = 0;
  int r_idx = 0;
  int aw_idx = 0;
  int w_idx = 0;
  int ar_idx = 0;
  int src_errors = 0;
  int dst_errors = 0;

  // Addresses from 0x40 up have no subordinate behind them
  function automatic axi_cdc_pkg::resp_t resp_for(axi_cdc_pkg::addr_t addr);
    if (addr >= 32'h40) begin
      return axi_cdc_pkg::RESP_DECERR;
    end
    return axi_cdc_pkg::RESP_OKAY;
  endfunction

  // Stimulus sets the protection bits from address bits [4:2]
  function automatic axi_cdc_pkg::prot_t prot_for(axi_cdc_pkg::addr_t addr);
    return addr[4:2];
  endfunction

  always @(posedge src_clk_i) begin
    if (exp_valid_i && exp_write_i && n_wr < 64) begin
      wr_addr[n_wr] = exp_addr_i;
      wr_data[n_wr] = exp_data_i;
      n_wr = n_wr + 1;
    end else if (exp_valid_i && !exp_write_i && n_rd < 64) begin
      rd_addr[n_rd] = exp_addr_i;
      rd_data[n_rd] = exp_data_i;
      n_rd = n_rd + 1;
    end
    if (!started_i && (src_resp_i.b_valid || src_resp_i.r_valid)) begin
      $display("error at time %0t: src response valid before any stimulus", $time);
      src_errors = src_errors + 1;
    end
    if (src_resp_i.b_valid && src_req_i.b_ready) begin
      if (b_idx >= n_wr) begin
        $display("error at time %0t: unexpected B beat", $time);
        src_errors = src_errors + 1;
      end else if (src_resp_i.b.resp != resp_for(wr_addr[b_idx])) begin
        $display("error at time %0t: B resp %0d for addr %h, expected %0d", $time,
                 src_resp_i.b.resp, wr_addr[b_idx], resp_for(wr_addr[b_idx]));
        src_errors = src_errors + 1;
      end
      b_idx = b_idx + 1;
    end
    if (src_resp_i.r_valid && src_req_i.r_ready) begin
      if (r_idx >= n_rd) begin
        $display("error at time %0t: unexpected R beat", $time);
        src_errors = src_errors + 1;
      end else if (src_resp_i.r.data != rd_data[r_idx] ||
                   src_resp_i.r.resp != resp_for(rd_addr[r_idx])) begin
        $display("error at time %0t: R data %h resp %0d for addr %h, expected %h resp %0d",
                 $time, src_resp_i.r.data, src_resp_i.r.resp, rd_addr[r_idx],
                 rd_data[r_idx], resp_for(rd_addr[r_idx]));
        src_errors = src_errors + 1;
      end
      r_idx = r_idx + 1;
    end
  end

  always @(posedge dst_clk_i) begin
    if (!started_i && (dst_req_i.aw_valid || dst_req_i.w_valid || dst_req_i.ar_valid)) begin
      $display("error at time %0t: dst request valid before any stimulus", $time);
      dst_errors = dst_errors + 1;
    end
    if (dst_req_i.aw_valid && dst_resp_i.aw_ready) begin
      if (aw_idx >= n_wr || dst_req_i.aw.addr != wr_addr[aw_idx] ||
          dst_req_i.aw.prot != prot_for(wr_addr[aw_idx])) begin
        $display("error at time %0t: AW beat %0d with addr %h prot %0d not as expected",
                 $time, aw_idx, dst_req_i.aw.addr, dst_req_i.aw.prot);
        dst_errors = dst_errors + 1;
      end
      aw_idx = aw_idx + 1;
    end
    if (dst_req_i.w_valid && dst_resp_i.w_ready) begin
      if (w_idx >= n_wr || dst_req_i.w.data != wr_data[w_idx] || dst_req_i.w.strb != 4'hf) begin
        $display("error at time %0t: W beat %0d with data %h out of order or extra",
                 $time, w_idx, dst_req_i.w.data);
        dst_errors = dst_errors + 1;
      end
      w_idx = w_idx + 1;
    end
    if (dst_req_i.ar_valid && dst_resp_i.ar_ready) begin
      if (ar_idx >= n_rd || dst_req_i.ar.addr != rd_addr[ar_idx] ||
          dst_req_i.ar.prot != prot_for(rd_addr[ar_idx])) begin
        $display("error at time %0t: AR beat %0d with addr %h prot %0d not as expected",
                 $time, ar_idx, dst_req_i.ar.addr, dst_req_i.ar.prot);
        dst_errors = dst_errors + 1;
      end
      ar_idx = ar_idx + 1;
    end
  end

  assign error_count_o = src_errors + dst_errors;
  assign b_count_o     = b_idx;
  assign r_count_o     = r_idx;

endmodule

/* tb_axi_cdc.sv */
// Testbench for the AXI4-Lite crossing, stimulus from axi_cdc_testdata.txt.
// Destination side is a 16-word memory model, DECERR from address 0x40 up.
// Ready signals are gated by LFSR bits; an H line forces dst ready low.
module tb_axi_cdc;

  localparam int TIMEOUT_CYCLES = 2000;

  logic src_clk, dst_clk, arst_n;
  axi_cdc_pkg::axi_req_t src_req, stim_req, dst_req;
  axi_cdc_pkg::axi_rsp_t src_resp, dst_resp;
  logic src_b_ready, src_r_ready;
  logic [1:0] src_bp;
  logic started, exp_valid, exp_write;
  axi_cdc_pkg::addr_t exp_addr;
  axi_cdc_pkg::data_t exp_data;
  int error_count, b_count, r_count;
  logic [31:0] lfsr;
  time hold_end;
  logic timed_out;

  tb_clk_gen #(.PERIOD(10), .OFFSET(0)) i_src_clk (.clk_o(src_clk));
  tb_clk_gen #(.PERIOD(10), .OFFSET(3)) i_dst_clk (.clk_o(dst_clk));

  axi_cdc i_axi_cdc (
    .src_clk_i  (src_clk),
    .dst_clk_i  (dst_clk),
    .arst_n_i   (arst_n),
    .src_req_i  (src_req),
    .src_resp_o (src_resp),
    .dst_req_o  (dst_req),
    .dst_resp_i (dst_resp)
  );

  tb_axi_cdc_checker i_checker (
    .src_clk_i     (src_clk),
    .dst_clk_i     (dst_clk),
    .started_i     (started),
    .exp_valid_i   (exp_valid),
    .exp_write_i   (exp_write),
    .exp_addr_i    (exp_addr),
    .exp_data_i    (exp_data),
    .src_req_i     (src_req),
    .src_resp_i    (src_resp),
    .dst_req_i     (dst_req),
    .dst_resp_i    (dst_resp),
    .error_count_o (error_count),
    .b_count_o     (b_count),
    .r_count_o     (r_count)
  );

  always_comb begin
    src_req         = stim_req;
    src_req.b_ready = src_b_ready;
    src_req.r_ready = src_r_ready;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  always @(negedge src_clk) begin
    src_b_ready = arst_n & src_bp[0];
    src_r_ready = arst_n & src_bp[1];
  end

  // Destination memory model captures beats on the rising edge and drives on the falling edge
  always begin : dst_memory
    logic [31:0] mem [16];
    logic have_aw, have_w, have_ar, b_done, r_done, hold;
    axi_cdc_pkg::addr_t aw_addr, ar_addr;
    axi_cdc_pkg::data_t w_data;
    @(posedge dst_clk);
    if (dst_req.aw_valid && dst_resp.aw_ready) begin
      have_aw = 1'b1;
      aw_addr = dst_req.aw.addr;
    end
    if (dst_req.w_valid && dst_resp.w_ready) begin
      have_w = 1'b1;
      w_data = dst_req.w.data;
    end
    if (dst_req.ar_valid && dst_resp.ar_ready) begin
      have_ar = 1'b1;
      ar_addr = dst_req.ar.addr;
    end
    b_done = dst_resp.b_valid && dst_req.b_ready;
    r_done = dst_resp.r_valid && dst_req.r_ready;
    @(negedge dst_clk);
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) begin
        mem[i] = '0;
      end
      have_aw  = 1'b0;
      have_w   = 1'b0;
      have_ar  = 1'b0;
      dst_resp = '0;
    end else begin
      if (b_done) dst_resp.b_valid = 1'b0;
      if (r_done) dst_resp.r_valid = 1'b0;
      if (have_aw && have_w && !dst_resp.b_valid) begin
        if (aw_addr >= 32'h40) begin
          dst_resp.b.resp = axi_cdc_pkg::RESP_DECERR;
        end else begin
          mem[aw_addr[5:2]] = w_data;
          dst_resp.b.resp   = axi_cdc_pkg::RESP_OKAY;
        end
        dst_resp.b_valid = 1'b1;
        have_aw = 1'b0;
        have_w  = 1'b0;
      end
      if (have_ar && !dst_resp.r_valid) begin
        if (ar_addr >= 32'h40) begin
          dst_resp.r.data = '0;
          dst_resp.r.resp = axi_cdc_pkg::RESP_DECERR;
        end else begin
          dst_resp.r.data = mem[ar_addr[5:2]];
          dst_resp.r.resp = axi_cdc_pkg::RESP_OKAY;
        end
        dst_resp.r_valid = 1'b1;
        have_ar = 1'b0;
      end
      hold = $time < hold_end;
      lfsr = lfsr_step(lfsr);
      dst_resp.aw_ready = !have_aw && !hold && lfsr[0];
      lfsr = lfsr_step(lfsr);
      dst_resp.w_ready = !have_w && !hold && lfsr[0];
      lfsr = lfsr_step(lfsr);
      dst_resp.ar_ready = !have_ar && !hold && lfsr[0];
      lfsr = lfsr_step(lfsr);
      src_bp[0] = lfsr[0];
      lfsr = lfsr_step(lfsr);
      src_bp[1] = lfsr[0];
    end
  end

  task automatic post_expect(input logic write, input axi_cdc_pkg::addr_t addr,
                             input axi_cdc_pkg::data_t data);
    exp_write = write;
    exp_addr  = addr;
    exp_data  = data;
    exp_valid = 1'b1;
    @(negedge src_clk);
    exp_valid = 1'b0;
  endtask

  task automatic send_write(input axi_cdc_pkg::addr_t addr, input axi_cdc_pkg::data_t data);
    int cycles;
    logic aw_fire, w_fire;
    cycles = 0;
    stim_req.aw.addr  = addr;
    // Protection bits follow the address so each beat carries its own value
    stim_req.aw.prot  = addr[4:2];
    stim_req.w.data   = data;
    stim_req.w.strb   = 4'hf;
    stim_req.aw_valid = 1'b1;
    stim_req.w_valid  = 1'b1;
    while ((stim_req.aw_valid || stim_req.w_valid) && !timed_out) begin
      @(posedge src_clk);
      aw_fire = stim_req.aw_valid && src_resp.aw_ready;
      w_fire  = stim_req.w_valid && src_resp.w_ready;
      @(negedge src_clk);
      if (aw_fire) stim_req.aw_valid = 1'b0;
      if (w_fire) stim_req.w_valid = 1'b0;
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: write to %h was never accepted", addr);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic send_read(input axi_cdc_pkg::addr_t addr);
    int cycles;
    logic ar_fire;
    cycles = 0;
    stim_req.ar.addr  = addr;
    stim_req.ar.prot  = addr[4:2];
    stim_req.ar_valid = 1'b1;
    while (stim_req.ar_valid && !timed_out) begin
      @(posedge src_clk);
      ar_fire = src_resp.ar_ready;
      @(negedge src_clk);
      if (ar_fire) stim_req.ar_valid = 1'b0;
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: read of %h was never accepted", addr);
        timed_out = 1'b1;
      end
    end
  endtask

  // Waits until the checker has seen the given totals of B and R beats
  task automatic wait_responses(input int b_target, input int r_target);
    int cycles;
    cycles = 0;
    while ((b_count < b_target || r_count < r_target) && !timed_out) begin
      @(negedge src_clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: response did not arrive, %0d of %0d B and %0d of %0d R seen",
                 b_count, b_target, r_count, r_target);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_ready;
    int cycles;
    cycles = 0;
    while (!(src_resp.aw_ready && src_resp.w_ready && src_resp.ar_ready) && !timed_out) begin
      @(negedge src_clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: source ready signals never rose after reset");
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    int fd, n_fields, n_writes, n_reads, burst_left;
    string line, op;
    logic [31:0] a, d;
    arst_n      = 1'b0;
    stim_req    = '0;
    exp_valid   = 1'b0;
    exp_write   = 1'b0;
    exp_addr    = '0;
    exp_data    = '0;
    started     = 1'b0;
    timed_out   = 1'b0;
    hold_end    = 0;
    lfsr        = 32'hf8c8;
    src_bp      = '0;
    src_b_ready = 1'b0;
    src_r_ready = 1'b0;
    dst_resp    = '0;
    n_writes    = 0;
    n_reads     = 0;
    burst_left  = 0;
    repeat (16) @(negedge src_clk);
    arst_n = 1'b1;
    wait_ready();
    // Quiet window where no valid may appear
    repeat (20) @(negedge src_clk);
    started = 1'b1;
    fd = $fopen("axi_cdc_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open axi_cdc_testdata.txt");
      timed_out = 1'b1;
    end
    while (fd != 0 && !$feof(fd) && !timed_out) begin
      line = "";
      void'($fgets(line, fd));
      n_fields = $sscanf(line, "%s %h %h", op, a, d);
      if (n_fields == 3 && op == "H") begin
        hold_end   = $time + a * 10;
        burst_left = d;
      end else if (n_fields == 3 && op == "W") begin
        post_expect(1'b1, a, d);
        send_write(a, d);
        n_writes++;
        if (burst_left > 0) begin
          burst_left--;
        end
        if (burst_left == 0) begin
          wait_responses(n_writes, n_reads);
        end
      end else if (n_fields == 3 && op == "R") begin
        post_expect(1'b0, a, d);
        send_read(a);
        n_reads++;
        wait_responses(n_writes, n_reads);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    repeat (10) @(negedge src_clk);
    $display("Summary: %0d errors, %0d of %0d B beats, %0d of %0d R beats, timeout %0d",
             error_count, b_count, n_writes, r_count, n_reads, timed_out);
    if (!timed_out && error_count == 0 && b_count == n_writes && r_count == n_reads &&
        n_writes > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* axi_cdc_testdata.txt */
# Columns: op addr data. W writes data; R reads and expects data;
# H holds dst ready low for addr cycles while the next data writes go back-to-back
W 00000000 11110000
W 00000004 22220001
R 00000000 11110000
R 00000004 22220001
W 00000040 deadbeef
R 00000044 00000000
W 0000003c a5a5a5a5
R 0000003c a5a5a5a5
H 00000028 00000006
W 00000008 b0000001
W 0000000c b0000002
W 00000010 b0000003
W 00000014 b0000004
W 00000018 b0000005
W 0000001c b0000006
R 00000008 b0000001
R 00000014 b0000004
R 0000001c b0000006
R 00000080 00000000
R 00000020 00000000

/* files.f */
axi_cdc_pkg.sv
cdc_fifo_src.sv
cdc_fifo_dst.sv
axi_cdc_src.sv
axi_cdc_dst.sv
axi_cdc.sv
tb_clk_gen.sv
tb_axi_cdc_checker.sv
tb_axi_cdc.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the AXI CDC testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_axi_cdc -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_axi_cdc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
